// File: exu_subsys.f
+incdir+source
+incdir+tb
source/rv_pkg.sv
source/exu_alu.sv
source/exu_csr.sv
source/exu.sv
source/lsu_sram.sv
source/exu_top.sv
tb/exu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exu_tb \
  -f exu_subsys.f --Mdir obj_dir -o exu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/exu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// File: source/exu.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module exu (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  input  wire rv_pkg::word_t    inst_i,
  input  wire rv_pkg::word_t    pc_i,
  input  wire rv_pkg::word_t    imm_i,
  input  wire rv_pkg::word_t    op1_i,
  input  wire rv_pkg::word_t    op2_i,
  input  wire rv_pkg::word_t    opj_i,
  input  wire rv_pkg::alu_op_t  alu_op_i,
  input  wire rv_pkg::reg_idx_t rd_i,
  input  wire                   ren_i,
  input  wire                   wen_i,
  input  wire                   system_i,
  input  wire                   priv_i,
  input  wire                   csr_wen_i,
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output rv_pkg::reg_idx_t      rd_o,
  output rv_pkg::word_t         rd_wdata_o,
  output rv_pkg::word_t         npc_o,
  output logic                  take_npc_o,
  output rv_pkg::word_t         pc_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output rv_pkg::word_t         mem_addr_o,
  output rv_pkg::word_t         mem_wdata_o,
  input  wire                   mem_resp_i,
  input  wire rv_pkg::word_t    mem_rdata_i
);

  localparam rv_pkg::word_t MCAUSE_ECALL_M = 32'd11;

  rv_pkg::exu_state_e state_q;
  logic               accept;
  logic               complete;

  logic [6:0]         opcode_q;
  logic [2:0]         f3_q;
  rv_pkg::csr_addr_t  csr_field_q;
  rv_pkg::word_t      pc_q;
  rv_pkg::word_t      src1_q;
  rv_pkg::word_t      src2_q;
  rv_pkg::word_t      target_q;
  rv_pkg::word_t      addr_q;
  rv_pkg::alu_op_t    alu_op_q;
  rv_pkg::reg_idx_t   rd_q;
  logic               ren_q;
  logic               wen_q;
  logic               system_q;
  logic               priv_q;
  logic               csr_wen_q;
  rv_pkg::word_t      mem_rdata_q;

  rv_pkg::word_t      alu_res;
  rv_pkg::csr_addr_t  csr_addr;
  rv_pkg::word_t      csr_rdata;
  rv_pkg::word_t      csr_wdata;
  rv_pkg::word_t      mepc;
  rv_pkg::word_t      mtvec;
  logic               is_ecall;
  logic               is_mret;
  logic               take;

  assign out_valid_o = (state_q == rv_pkg::DONE);
  assign complete    = out_valid_o & out_ready_i;
  // a new instruction may enter as the previous one leaves
  assign in_ready_o  = (state_q == rv_pkg::IDLE) | complete;
  assign accept      = in_valid_i & in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= rv_pkg::IDLE;
    end else begin
      case (state_q)
        rv_pkg::IDLE, rv_pkg::DONE: begin
          if (accept) begin
            state_q <= (ren_i | wen_i) ? rv_pkg::MEM_REQ : rv_pkg::DONE;
          end else if (complete) begin
            state_q <= rv_pkg::IDLE;
          end
        end
        rv_pkg::MEM_REQ: state_q <= mem_resp_i ? rv_pkg::DONE : rv_pkg::MEM_WAIT;
        rv_pkg::MEM_WAIT: begin
          if (mem_resp_i) begin
            state_q <= rv_pkg::DONE;
          end
        end
        default: state_q <= rv_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opcode_q    <= inst_i[6:0];
      f3_q        <= inst_i[14:12];
      csr_field_q <= imm_i[11:0];
      pc_q        <= pc_i;
      src1_q      <= op1_i;
      src2_q      <= op2_i;
      target_q    <= opj_i + imm_i;
      addr_q      <= op1_i + imm_i;
      alu_op_q    <= alu_op_i;
      rd_q        <= rd_i;
      ren_q       <= ren_i;
      wen_q       <= wen_i;
      system_q    <= system_i;
      priv_q      <= priv_i;
      csr_wen_q   <= csr_wen_i;
    end
    if (mem_resp_i) begin
      mem_rdata_q <= mem_rdata_i;
    end
  end

  // request held from MEM_REQ until the response edge
  assign mem_req_o   = (state_q == rv_pkg::MEM_REQ) | (state_q == rv_pkg::MEM_WAIT);
  assign mem_we_o    = wen_q;
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = src2_q;

  exu_alu u_alu (
    .src1_i (src1_q),
    .src2_i (src2_q),
    .op_i   (alu_op_q),
    .res_o  (alu_res)
  );

  assign is_ecall = system_q & priv_q & (csr_field_q == `RV_SYS_ECALL);
  assign is_mret  = system_q & priv_q & (csr_field_q == `RV_SYS_MRET);

  always_comb begin
    if (is_ecall) begin
      csr_addr = `RV_CSR_MCAUSE;
    end else if (is_mret) begin
      csr_addr = `RV_CSR_MSTATUS;
    end else begin
      csr_addr = csr_field_q;
    end
  end

  // immediate forms carry zimm in op1
  always_comb begin
    if (is_ecall) begin
      csr_wdata = MCAUSE_ECALL_M;
    end else if (is_mret) begin
      // mie <= mpie, mpie <= 1
      csr_wdata = {csr_rdata[31:8], 1'b1, csr_rdata[6:4], csr_rdata[7], csr_rdata[2:0]};
    end else begin
      case (f3_q)
        `RV_F3_CSRRW, `RV_F3_CSRRWI: csr_wdata = src1_q;
        `RV_F3_CSRRS, `RV_F3_CSRRSI: csr_wdata = csr_rdata | src1_q;
        `RV_F3_CSRRC, `RV_F3_CSRRCI: csr_wdata = csr_rdata & ~src1_q;
        default: csr_wdata = '0;
      endcase
    end
  end

  exu_csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .wen_i   (complete & (csr_wen_q | is_ecall | is_mret)),
    .ecall_i (complete & is_ecall),
    .raddr_i (csr_addr),
    .wdata_i (csr_wdata),
    .epc_i   (pc_q),
    .rdata_o (csr_rdata),
    .mepc_o  (mepc),
    .mtvec_o (mtvec)
  );

  always_comb begin
    if (rd_q == '0) begin
      rd_wdata_o = '0;
    end else if (ren_q) begin
      rd_wdata_o = mem_rdata_q;
    end else if (system_q) begin
      rd_wdata_o = csr_rdata;
    end else begin
      rd_wdata_o = alu_res;
    end
  end

  always_comb begin
    npc_o = target_q;
    take  = 1'b0;
    if (is_ecall) begin
      npc_o = mtvec;
      take  = 1'b1;
    end else if (is_mret) begin
      npc_o = mepc;
      take  = 1'b1;
    end else begin
      case (opcode_q)
        `RV_OP_JAL, `RV_OP_JALR: take = 1'b1;
        // beq via sub, everything else via a nonzero compare
        `RV_OP_BRANCH: take = (alu_op_q == `RV_ALU_SUB) ? ~|alu_res : |alu_res;
        default: take = 1'b0;
      endcase
    end
  end

  assign take_npc_o = take & out_valid_o;
  assign rd_o       = rd_q;
  assign pc_o       = pc_q;

  a_stall_holds: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(rd_wdata_o)));

  a_no_accept_in_mem: assert property (@(posedge clk) disable iff (rst)
    (state_q inside {rv_pkg::MEM_REQ, rv_pkg::MEM_WAIT}) |-> !(in_valid_i && in_ready_o));

endmodule

`default_nettype wire

// File: source/exu_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module exu_alu (
  input  wire rv_pkg::word_t   src1_i,
  input  wire rv_pkg::word_t   src2_i,
  input  wire rv_pkg::alu_op_t op_i,
  output rv_pkg::word_t        res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;

  always_comb begin
    case (op_i)
      `RV_ALU_ADD: res_o = src1_i + src2_i;
      `RV_ALU_SUB: res_o = src1_i - src2_i;
      `RV_ALU_AND: res_o = src1_i & src2_i;
      `RV_ALU_OR: res_o = src1_i | src2_i;
      `RV_ALU_XOR: res_o = src1_i ^ src2_i;
      `RV_ALU_SLL: res_o = src1_i << shamt;
      `RV_ALU_SRL: res_o = src1_i >> shamt;
      `RV_ALU_SRA: res_o = rv_pkg::word_t'($signed(src1_i) >>> shamt);
      // compares give 0 or 1, branches test for nonzero
      `RV_ALU_SLT: res_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
      `RV_ALU_SLTU: res_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
      `RV_ALU_SGE: res_o = {{(`RV_XLEN-1){1'b0}}, ~lt_s};
      `RV_ALU_SGEU: res_o = {{(`RV_XLEN-1){1'b0}}, ~lt_u};
      default: res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/exu_csr.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module exu_csr (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    wen_i,
  input  wire                    ecall_i,
  input  wire rv_pkg::csr_addr_t raddr_i,
  input  wire rv_pkg::word_t     wdata_i,
  input  wire rv_pkg::word_t     epc_i,
  output rv_pkg::word_t          rdata_o,
  output rv_pkg::word_t          mepc_o,
  output rv_pkg::word_t          mtvec_o
);

  rv_pkg::word_t mstatus_q;
  rv_pkg::word_t mtvec_q;
  rv_pkg::word_t mepc_q;
  rv_pkg::word_t mcause_q;
  logic          addr_known;

  always_comb begin
    addr_known = 1'b1;
    case (raddr_i)
      `RV_CSR_MSTATUS: rdata_o = mstatus_q;
      `RV_CSR_MTVEC: rdata_o = mtvec_q;
      `RV_CSR_MEPC: rdata_o = mepc_q;
      `RV_CSR_MCAUSE: rdata_o = mcause_q;
      default: begin
        rdata_o    = '0;
        addr_known = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (wen_i) begin
        case (raddr_i)
          `RV_CSR_MSTATUS: mstatus_q <= wdata_i;
          `RV_CSR_MTVEC: mtvec_q <= wdata_i;
          `RV_CSR_MEPC: mepc_q <= wdata_i;
          `RV_CSR_MCAUSE: mcause_q <= wdata_i;
          default: begin
          end
        endcase
      end
      // second port, trap pc alongside the mcause write
      if (ecall_i) begin
        mepc_q <= epc_i;
      end
    end
  end

  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

  // decode must never hand a write to a csr that does not exist here
  a_wen_known_addr: assert property (@(posedge clk) disable iff (rst)
    wen_i |-> addr_known);

endmodule

`default_nettype wire

// File: source/exu_top.sv
`timescale 1ns/10ps
`default_nettype none

module exu_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  input  wire rv_pkg::word_t    inst_i,
  input  wire rv_pkg::word_t    pc_i,
  input  wire rv_pkg::word_t    imm_i,
  input  wire rv_pkg::word_t    op1_i,
  input  wire rv_pkg::word_t    op2_i,
  input  wire rv_pkg::word_t    opj_i,
  input  wire rv_pkg::alu_op_t  alu_op_i,
  input  wire rv_pkg::reg_idx_t rd_i,
  input  wire                   ren_i,
  input  wire                   wen_i,
  input  wire                   system_i,
  input  wire                   priv_i,
  input  wire                   csr_wen_i,
  output logic                  out_valid_o,
  input  wire                   out_ready_i,
  output rv_pkg::reg_idx_t      rd_o,
  output rv_pkg::word_t         rd_wdata_o,
  output rv_pkg::word_t         npc_o,
  output logic                  take_npc_o,
  output rv_pkg::word_t         pc_o
);

  logic          mem_req;
  logic          mem_we;
  rv_pkg::word_t mem_addr;
  rv_pkg::word_t mem_wdata;
  logic          mem_resp;
  rv_pkg::word_t mem_rdata;

  exu u_exu (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .opj_i       (opj_i),
    .alu_op_i    (alu_op_i),
    .rd_i        (rd_i),
    .ren_i       (ren_i),
    .wen_i       (wen_i),
    .system_i    (system_i),
    .priv_i      (priv_i),
    .csr_wen_i   (csr_wen_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wdata_o  (rd_wdata_o),
    .npc_o       (npc_o),
    .take_npc_o  (take_npc_o),
    .pc_o        (pc_o),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_resp_i  (mem_resp),
    .mem_rdata_i (mem_rdata)
  );

  lsu_sram u_sram (
    .clk     (clk),
    .rst     (rst),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .resp_o  (mem_resp),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: source/lsu_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module lsu_sram (
  input  wire                clk,
  input  wire                rst,
  input  wire                req_i,
  input  wire                we_i,
  input  wire rv_pkg::word_t addr_i,
  input  wire rv_pkg::word_t wdata_i,
  output logic               resp_o,
  output rv_pkg::word_t      rdata_o
);

  localparam int IDX_W = $clog2(`RV_MEM_WORDS);
  localparam int CNT_W = $clog2(`RV_MEM_LATENCY + 1);

  rv_pkg::word_t    mem_q [`RV_MEM_WORDS];
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             we_q;
  logic [IDX_W-1:0] idx_q;
  rv_pkg::word_t    wdata_q;
  logic             take_req;

  assign take_req = req_i & ~busy_q;

  // pulse on the last cycle of the countdown
  assign resp_o  = busy_q & (cnt_q == '0);
  assign rdata_o = mem_q[idx_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (take_req) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(`RV_MEM_LATENCY - 1);
    end else if (resp_o) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  // upper address bits wrap onto the same words
  always_ff @(posedge clk) begin
    if (take_req) begin
      we_q    <= we_i;
      idx_q   <= addr_i[IDX_W+1:2];
      wdata_q <= wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_o && we_q) begin
      mem_q[idx_q] <= wdata_q;
    end
  end

  a_resp_single: assert property (@(posedge clk) disable iff (rst)
    resp_o |=> !resp_o);

endmodule

`default_nettype wire

// File: source/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN 32

// major opcodes
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_SYSTEM 7'b1110011

// alu operations
`define RV_ALU_ADD  4'd0
`define RV_ALU_SUB  4'd1
`define RV_ALU_AND  4'd2
`define RV_ALU_OR   4'd3
`define RV_ALU_XOR  4'd4
`define RV_ALU_SLL  4'd5
`define RV_ALU_SRL  4'd6
`define RV_ALU_SRA  4'd7
`define RV_ALU_SLT  4'd8
`define RV_ALU_SLTU 4'd9
`define RV_ALU_SGE  4'd10
`define RV_ALU_SGEU 4'd11

// csr instruction func3
`define RV_F3_CSRRW  3'b001
`define RV_F3_CSRRS  3'b010
`define RV_F3_CSRRC  3'b011
`define RV_F3_CSRRWI 3'b101
`define RV_F3_CSRRSI 3'b110
`define RV_F3_CSRRCI 3'b111

`define RV_SYS_ECALL 12'h000
`define RV_SYS_MRET  12'h302

`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MTVEC   12'h305
`define RV_CSR_MEPC    12'h341
`define RV_CSR_MCAUSE  12'h342

// data memory
`define RV_MEM_LATENCY 2
`define RV_MEM_WORDS   256

`endif

// File: source/rv_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  // data word, address or pc
  typedef logic [`RV_XLEN-1:0] word_t;

  // rv32e has 16 registers
  typedef logic [3:0] reg_idx_t;

  typedef logic [3:0] alu_op_t;

  typedef logic [11:0] csr_addr_t;

  // execute unit sequencing
  typedef enum logic [1:0] {
    IDLE,
    MEM_REQ,
    MEM_WAIT,
    DONE
  } exu_state_e;

endpackage

`default_nettype wire

// File: tb/exu_ref.svh
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

localparam logic [31:0] SEED = 32'h8be1e0b9;

logic [31:0]   stim_state;
// expected memory and csr contents, in issue order
rv_pkg::word_t shadow_mem [`RV_MEM_WORDS];
rv_pkg::word_t shadow_csr [4];

function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// halves swapped so the low bits are usable too
function automatic logic [31:0] rnd();
  stim_state = lcg_step(stim_state);
  return {stim_state[15:0], stim_state[31:16]};
endfunction

function automatic rv_pkg::word_t ref_alu(input rv_pkg::alu_op_t op,
                                          input rv_pkg::word_t a,
                                          input rv_pkg::word_t b);
  case (op)
    `RV_ALU_ADD: return a + b;
    `RV_ALU_SUB: return a - b;
    `RV_ALU_AND: return a & b;
    `RV_ALU_OR: return a | b;
    `RV_ALU_XOR: return a ^ b;
    `RV_ALU_SLL: return a << b[4:0];
    `RV_ALU_SRL: return a >> b[4:0];
    `RV_ALU_SRA: return rv_pkg::word_t'($signed(a) >>> b[4:0]);
    `RV_ALU_SLT: return {31'd0, $signed(a) < $signed(b)};
    `RV_ALU_SLTU: return {31'd0, a < b};
    `RV_ALU_SGE: return {31'd0, $signed(a) >= $signed(b)};
    `RV_ALU_SGEU: return {31'd0, a >= b};
    default: return 32'd0;
  endcase
endfunction

// beq is a sub that must come out zero
function automatic logic ref_branch_take(input rv_pkg::alu_op_t op,
                                         input rv_pkg::word_t a,
                                         input rv_pkg::word_t b);
  rv_pkg::word_t r;
  r = ref_alu(op, a, b);
  if (op == `RV_ALU_SUB) begin
    return r == 32'd0;
  end
  return r != 32'd0;
endfunction

function automatic rv_pkg::word_t ref_csr_next(input logic [2:0] f3,
                                               input rv_pkg::word_t old,
                                               input rv_pkg::word_t src);
  case (f3)
    `RV_F3_CSRRW, `RV_F3_CSRRWI: return src;
    `RV_F3_CSRRS, `RV_F3_CSRRSI: return old | src;
    `RV_F3_CSRRC, `RV_F3_CSRRCI: return old & ~src;
    default: return old;
  endcase
endfunction

function automatic rv_pkg::word_t ref_mret_status(input rv_pkg::word_t old);
  rv_pkg::word_t r;
  r    = old;
  r[3] = old[7];
  r[7] = 1'b1;
  return r;
endfunction

function automatic int csr_slot(input rv_pkg::csr_addr_t addr);
  case (addr)
    `RV_CSR_MSTATUS: return 0;
    `RV_CSR_MTVEC: return 1;
    `RV_CSR_MEPC: return 2;
    default: return 3;
  endcase
endfunction

`endif

// File: tb/exu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_consts.svh"

module exu_tb;

  localparam logic [6:0] OPC_ALU   = 7'b0110011;
  // {ren, wen, system, priv, csr_wen}
  localparam logic [4:0] CTL_NONE  = 5'b00000;
  localparam logic [4:0] CTL_LOAD  = 5'b10000;
  localparam logic [4:0] CTL_STORE = 5'b01000;
  localparam logic [4:0] CTL_CSR   = 5'b00101;
  localparam logic [4:0] CTL_TRAP  = 5'b00110;

  logic              clk = 1'b0;
  logic              rst;
  logic              in_valid_i;
  logic              in_ready_o;
  rv_pkg::word_t     inst_i;
  rv_pkg::word_t     pc_i;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     op1_i;
  rv_pkg::word_t     op2_i;
  rv_pkg::word_t     opj_i;
  rv_pkg::alu_op_t   alu_op_i;
  rv_pkg::reg_idx_t  rd_i;
  logic              ren_i;
  logic              wen_i;
  logic              system_i;
  logic              priv_i;
  logic              csr_wen_i;
  logic              out_valid_o;
  logic              out_ready_i;
  rv_pkg::reg_idx_t  rd_o;
  rv_pkg::word_t     rd_wdata_o;
  rv_pkg::word_t     npc_o;
  logic              take_npc_o;
  rv_pkg::word_t     pc_o;

  rv_pkg::word_t     exp_rd [$];
  rv_pkg::reg_idx_t  exp_rd_idx [$];
  rv_pkg::word_t     exp_pc [$];
  logic              exp_take [$];
  rv_pkg::word_t     exp_npc [$];
  rv_pkg::word_t     st_addr [40];
  rv_pkg::word_t     next_pc;
  logic              stall_en;
  logic [31:0]       stall_state;
  int                issued;
  int                cycles;
  int                value_errs;
  int                other_errs;

  `include "exu_ref.svh"

  exu_top UUT (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .opj_i       (opj_i),
    .alu_op_i    (alu_op_i),
    .rd_i        (rd_i),
    .ren_i       (ren_i),
    .wen_i       (wen_i),
    .system_i    (system_i),
    .priv_i      (priv_i),
    .csr_wen_i   (csr_wen_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wdata_o  (rd_wdata_o),
    .npc_o       (npc_o),
    .take_npc_o  (take_npc_o),
    .pc_o        (pc_o)
  );

  always #5 clk = ~clk;

  // drives one decoded instruction and holds it until accepted
  task automatic issue(input logic [6:0] opc, input logic [2:0] f3,
                       input rv_pkg::alu_op_t op, input rv_pkg::word_t a,
                       input rv_pkg::word_t b, input rv_pkg::word_t j,
                       input rv_pkg::word_t imm, input rv_pkg::reg_idx_t rd,
                       input logic [4:0] ctl, input rv_pkg::word_t e_rd,
                       input logic e_take, input rv_pkg::word_t e_npc);
    inst_i   = {17'd0, f3, 5'd0, opc};
    pc_i     = next_pc;
    imm_i    = imm;
    op1_i    = a;
    op2_i    = b;
    opj_i    = j;
    alu_op_i = op;
    rd_i     = rd;
    {ren_i, wen_i, system_i, priv_i, csr_wen_i} = ctl;
    in_valid_i = 1'b1;
    // x0 always reads back as zero
    exp_rd.push_back((rd == 4'd0) ? 32'd0 : e_rd);
    exp_rd_idx.push_back(rd);
    exp_pc.push_back(next_pc);
    exp_take.push_back(e_take);
    exp_npc.push_back(e_npc);
    @(negedge clk);
    while (!in_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
    issued     = issued + 1;
    next_pc    = next_pc + 32'd4;
  endtask

  task automatic alu_op(input rv_pkg::alu_op_t op, input rv_pkg::word_t a,
                        input rv_pkg::word_t b, input rv_pkg::reg_idx_t rd);
    issue(OPC_ALU, 3'd0, op, a, b, 32'd0, 32'd0, rd, CTL_NONE,
          ref_alu(op, a, b), 1'b0, 32'd0);
  endtask

  function automatic rv_pkg::alu_op_t branch_compare(input logic [2:0] sel);
    case (sel)
      3'd0: return `RV_ALU_SUB;
      3'd1: return `RV_ALU_XOR;
      3'd2: return `RV_ALU_SLT;
      3'd3: return `RV_ALU_SGE;
      3'd4: return `RV_ALU_SLTU;
      default: return `RV_ALU_SGEU;
    endcase
  endfunction

  task automatic branch(input rv_pkg::alu_op_t op, input rv_pkg::word_t a,
                        input rv_pkg::word_t b);
    logic [31:0]   r;
    rv_pkg::word_t imm;
    r   = rnd();
    imm = {{19{r[12]}}, r[12:1], 1'b0};
    issue(`RV_OP_BRANCH, 3'd0, op, a, b, next_pc, imm, 4'd0, CTL_NONE, 32'd0,
          ref_branch_take(op, a, b), next_pc + imm);
  endtask

  // link value comes from the alu as pc + 4
  task automatic jump(input logic [6:0] opc, input rv_pkg::word_t j,
                      input rv_pkg::word_t imm, input rv_pkg::reg_idx_t rd);
    issue(opc, 3'd0, `RV_ALU_ADD, next_pc, 32'd4, j, imm, rd, CTL_NONE,
          ref_alu(`RV_ALU_ADD, next_pc, 32'd4), 1'b1, j + imm);
  endtask

  task automatic store_word(input rv_pkg::word_t addr, input rv_pkg::word_t data);
    logic [31:0]   r;
    rv_pkg::word_t off;
    r   = rnd();
    off = {26'd0, r[3:0], 2'b00};
    shadow_mem[addr[9:2]] = data;
    issue(`RV_OP_STORE, 3'b010, `RV_ALU_ADD, addr - off, data, 32'd0, off, 4'd0,
          CTL_STORE, 32'd0, 1'b0, 32'd0);
  endtask

  task automatic load_word(input rv_pkg::word_t addr, input rv_pkg::reg_idx_t rd);
    logic [31:0]   r;
    rv_pkg::word_t off;
    r   = rnd();
    off = {26'd0, r[3:0], 2'b00};
    issue(`RV_OP_LOAD, 3'b010, `RV_ALU_ADD, addr - off, 32'd0, 32'd0, off, rd,
          CTL_LOAD, shadow_mem[addr[9:2]], 1'b0, 32'd0);
  endtask

  task automatic csr_access(input logic [2:0] f3, input rv_pkg::csr_addr_t addr,
                            input rv_pkg::word_t src, input rv_pkg::reg_idx_t rd);
    int            slot;
    rv_pkg::word_t old;
    slot = csr_slot(addr);
    old  = shadow_csr[slot];
    shadow_csr[slot] = ref_csr_next(f3, old, src);
    issue(`RV_OP_SYSTEM, f3, `RV_ALU_ADD, src, 32'd0, 32'd0, {20'd0, addr}, rd,
          CTL_CSR, old, 1'b0, 32'd0);
  endtask

  task automatic ecall_op();
    rv_pkg::word_t target;
    target = shadow_csr[csr_slot(`RV_CSR_MTVEC)];
    shadow_csr[csr_slot(`RV_CSR_MCAUSE)] = 32'd11;
    shadow_csr[csr_slot(`RV_CSR_MEPC)]   = next_pc;
    issue(`RV_OP_SYSTEM, 3'd0, `RV_ALU_ADD, 32'd0, 32'd0, 32'd0,
          {20'd0, `RV_SYS_ECALL}, 4'd0, CTL_TRAP, 32'd0, 1'b1, target);
  endtask

  task automatic mret_op();
    rv_pkg::word_t target;
    int            slot;
    target = shadow_csr[csr_slot(`RV_CSR_MEPC)];
    slot   = csr_slot(`RV_CSR_MSTATUS);
    shadow_csr[slot] = ref_mret_status(shadow_csr[slot]);
    issue(`RV_OP_SYSTEM, 3'd0, `RV_ALU_ADD, 32'd0, 32'd0, 32'd0,
          {20'd0, `RV_SYS_MRET}, 4'd0, CTL_TRAP, 32'd0, 1'b1, target);
  endtask

  // random backpressure on the result side
  initial begin
    out_ready_i = 1'b1;
    stall_state = lcg_step(SEED);
    forever begin
      @(posedge clk);
      #1;
      if (stall_en) begin
        stall_state = lcg_step(stall_state);
        out_ready_i = stall_state[20];
      end else begin
        out_ready_i = 1'b1;
      end
    end
  end

  // results are stable at the falling edge before their completion edge
  always @(negedge clk) begin : compare
    rv_pkg::word_t    e_rd;
    rv_pkg::reg_idx_t e_rd_idx;
    rv_pkg::word_t    e_pc;
    logic             e_take;
    rv_pkg::word_t    e_npc;
    if (!rst && out_valid_o && out_ready_i) begin
      if (exp_rd.size() == 0) begin
        $display("result completed at %0t with no instruction outstanding", $time);
        other_errs = other_errs + 1;
      end else begin
        e_rd     = exp_rd.pop_front();
        e_rd_idx = exp_rd_idx.pop_front();
        e_pc     = exp_pc.pop_front();
        e_take   = exp_take.pop_front();
        e_npc    = exp_npc.pop_front();
        if (rd_wdata_o !== e_rd) begin
          $display("Fail %0t rd_wdata_o expected %h actual %h", $time, e_rd, rd_wdata_o);
          value_errs = value_errs + 1;
        end
        if (rd_o !== e_rd_idx) begin
          $display("Fail %0t rd_o expected %h actual %h", $time, e_rd_idx, rd_o);
          value_errs = value_errs + 1;
        end
        if (pc_o !== e_pc) begin
          $display("Fail %0t pc_o expected %h actual %h", $time, e_pc, pc_o);
          value_errs = value_errs + 1;
        end
        if (take_npc_o !== e_take) begin
          $display("Fail %0t take_npc_o expected %b actual %b", $time, e_take, take_npc_o);
          value_errs = value_errs + 1;
        end
        if (e_take && npc_o !== e_npc) begin
          $display("Fail %0t npc_o expected %h actual %h", $time, e_npc, npc_o);
          value_errs = value_errs + 1;
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= 10 * issued + 200) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [31:0]       r;
    rv_pkg::word_t     a;
    rv_pkg::word_t     b;
    rv_pkg::csr_addr_t caddr;
    int                idx;
    rst        = 1'b1;
    in_valid_i = 1'b0;
    inst_i     = 32'd0;
    pc_i       = 32'd0;
    imm_i      = 32'd0;
    op1_i      = 32'd0;
    op2_i      = 32'd0;
    opj_i      = 32'd0;
    alu_op_i   = 4'd0;
    rd_i       = 4'd0;
    {ren_i, wen_i, system_i, priv_i, csr_wen_i} = CTL_NONE;
    stall_en   = 1'b0;
    stim_state = SEED;
    next_pc    = 32'h0000_1000;
    issued     = 0;
    value_errs = 0;
    other_errs = 0;
    for (int i = 0; i < 4; i++) begin
      shadow_csr[i] = 32'd0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (out_valid_o || take_npc_o || !in_ready_o) begin
      $display("outputs are not idle after reset");
      other_errs = other_errs + 1;
    end
    @(posedge clk);
    #1;

    for (int i = 0; i < 200; i++) begin
      r = rnd();
      alu_op(rv_pkg::alu_op_t'(r[7:0] % 8'd12), rnd(), rnd(), r[11:8]);
    end

    // equal operands half the time so beq and bge take
    for (int i = 0; i < 60; i++) begin
      r = rnd();
      a = rnd();
      b = r[0] ? a : rnd();
      branch(branch_compare(r[3:1]), a, b);
    end
    jump(`RV_OP_JAL, next_pc, 32'h0000_0100, 4'd1);
    jump(`RV_OP_JALR, rnd(), 32'h0000_0010, 4'd5);
    jump(`RV_OP_JALR, rnd(), 32'hffff_fff0, 4'd0);

    for (int i = 0; i < 40; i++) begin
      st_addr[i] = rnd() & 32'hffff_fffc;
      store_word(st_addr[i], rnd());
    end
    for (int i = 0; i < 40; i++) begin
      r   = rnd();
      idx = (i % 2 == 0) ? i : int'(rnd() % 32'd40);
      load_word(st_addr[idx], r[3:0]);
    end

    for (int c = 0; c < 2; c++) begin
      r     = rnd();
      caddr = (c == 0) ? `RV_CSR_MTVEC : `RV_CSR_MEPC;
      csr_access(`RV_F3_CSRRW, caddr, rnd(), 4'd3);
      csr_access(`RV_F3_CSRRS, caddr, rnd(), 4'd4);
      csr_access(`RV_F3_CSRRC, caddr, rnd(), 4'd5);
      csr_access(`RV_F3_CSRRSI, caddr, {27'd0, r[4:0]}, 4'd6);
      csr_access(`RV_F3_CSRRCI, caddr, 32'd7, 4'd7);
      csr_access(`RV_F3_CSRRS, caddr, 32'd0, 4'd8);
    end

    // trap entry and return
    csr_access(`RV_F3_CSRRW, `RV_CSR_MTVEC, rnd() & 32'hffff_fffc, 4'd1);
    ecall_op();
    csr_access(`RV_F3_CSRRS, `RV_CSR_MCAUSE, 32'd0, 4'd2);
    csr_access(`RV_F3_CSRRS, `RV_CSR_MEPC, 32'd0, 4'd3);
    csr_access(`RV_F3_CSRRW, `RV_CSR_MSTATUS, 32'h0000_0080, 4'd4);
    mret_op();
    csr_access(`RV_F3_CSRRS, `RV_CSR_MSTATUS, 32'd0, 4'd5);

    stall_en = 1'b1;
    for (int i = 0; i < 150; i++) begin
      r   = rnd();
      idx = int'(rnd() % 32'd40);
      case (r[2:0])
        3'd2: branch(branch_compare(r[10:8]), rnd(), rnd());
        3'd3: jump(`RV_OP_JAL, next_pc, {20'd0, r[17:8], 2'b00}, r[7:4]);
        3'd4: store_word(st_addr[idx], rnd());
        3'd5: load_word(st_addr[idx], r[7:4]);
        3'd6: begin
          caddr = r[11] ? `RV_CSR_MTVEC : `RV_CSR_MEPC;
          csr_access(r[9] ? `RV_F3_CSRRC : (r[8] ? `RV_F3_CSRRS : `RV_F3_CSRRW),
                     caddr, rnd(), r[7:4]);
        end
        default: alu_op(rv_pkg::alu_op_t'(r[15:8] % 8'd12), rnd(), rnd(), r[7:4]);
      endcase
    end
    stall_en = 1'b0;

    while (exp_rd.size() != 0) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    if (out_valid_o) begin
      $display("output still valid after the last instruction completed");
      other_errs = other_errs + 1;
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
